// ==== src/csr_gen_params.svh ====
// Stride must be nonzero, and FIFO depth must be a power of two well above the threshold

`ifndef CSR_GEN_PARAMS_SVH
`define CSR_GEN_PARAMS_SVH

// ------------------------------------------------------------------------
// Datapath widths
// ------------------------------------------------------------------------

// Edge index, start, end, stride and byte offset
`define CSR_INDEX_W 32

// Shift amount applied to the index to form the byte offset
`define CSR_SHIFT_W 5

// Route tag carried unchanged on every request
`define CSR_ROUTE_W 8

// ------------------------------------------------------------------------
// Request FIFO sizing
// ------------------------------------------------------------------------

// Number of stored requests
`define CSR_FIFO_DEPTH 16

// Occupancy where generation backs off
// Leaves headroom for the pushes still in flight
`define CSR_FIFO_PROG_THRESH 8

`endif

// ==== src/csr_ctrl_pkg.sv ====
// Control encodings for the index generator; state values are internal and may change

package csr_ctrl_pkg;

    // ------------------------------------------------------------------------
    // Offset shift direction
    // ------------------------------------------------------------------------

    // Left shift turns an element index into a byte offset
    typedef enum logic {
        SHIFT_RIGHT = 1'b0,
        SHIFT_LEFT  = 1'b1
    } shift_dir_t;

    // ------------------------------------------------------------------------
    // Sequencer states
    // ------------------------------------------------------------------------

    // RESET lasts one cycle after reset release
    // DONE lasts one cycle before the return to IDLE
    typedef enum logic [2:0] {
        RESET = 3'd0,
        IDLE  = 3'd1,
        SETUP = 3'd2,
        BUSY  = 3'd3,
        PAUSE = 3'd4,
        DONE  = 3'd5
    } index_gen_state_t;

endpackage : csr_ctrl_pkg

// ==== src/mem_req_pkg.sv ====
// Request record layout as stored in the FIFO; route sits in the top bits of the word

`include "csr_gen_params.svh"

package mem_req_pkg;

    // ------------------------------------------------------------------------
    // Memory request
    // ------------------------------------------------------------------------

    // One request per generated edge index
    // route   tag that steers the request downstream
    // offset  index shifted by the configured direction and amount
    // index   raw edge index from the counter
    typedef struct packed {
        logic [`CSR_ROUTE_W-1:0] route;
        logic [`CSR_INDEX_W-1:0] offset;
        logic [`CSR_INDEX_W-1:0] index;
    } mem_req_t;

endpackage : mem_req_pkg

// ==== src/index_counter.sv ====
// Unsigned wrapping counter; load wins over step and the owner must not raise both

`timescale 1ns/1ps

`include "csr_gen_params.svh"

module index_counter (
    input  logic                    ap_clk,
    input  logic                    areset_engine,
    input  logic                    load,
    input  logic                    step,
    input  logic [`CSR_INDEX_W-1:0] load_value,
    input  logic [`CSR_INDEX_W-1:0] stride,
    output logic [`CSR_INDEX_W-1:0] count
);

    // ------------------------------------------------------------------------
    // Count register
    // ------------------------------------------------------------------------

    always_ff @(posedge ap_clk) begin
        if (areset_engine) begin
            count <= '0;
        end else if (load) begin
            // New run starts from the captured start index
            count <= load_value;
        end else if (step) begin
            count <= count + stride;
        end
    end

    // ------------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------------

    // Sequencer loads only in SETUP and steps only in BUSY
    a_load_step_exclusive: assert property (
        @(posedge ap_clk) disable iff (areset_engine)
        !(load && step)
    ) else $error("index_counter: load and step high in the same cycle");

endmodule : index_counter

// ==== src/index_sequencer.sv ====
// One run per accepted configuration; count must reach index_end without wrapping

`timescale 1ns/1ps

`include "csr_gen_params.svh"

module index_sequencer
    import csr_ctrl_pkg::*;
(
    input  logic                    ap_clk,
    input  logic                    areset_engine,
    input  logic                    cfg_accept,
    input  logic [`CSR_INDEX_W-1:0] count,
    input  logic [`CSR_INDEX_W-1:0] index_end,
    input  logic                    prog_full,
    input  logic                    pause,
    output logic                    counter_load,
    output logic                    counter_step,
    output logic                    push,
    output logic                    ready,
    output logic                    done
);

    index_gen_state_t state;
    index_gen_state_t state_next;

    logic pause_q;
    logic below_end;
    logic hold;

    // ------------------------------------------------------------------------
    // Back-pressure and end of run
    // ------------------------------------------------------------------------

    // Pause goes through one register before it can stop a push
    always_ff @(posedge ap_clk) begin
        if (areset_engine) begin
            pause_q <= 1'b0;
        end else begin
            pause_q <= pause;
        end
    end

    assign below_end = (count < index_end);
    assign hold      = prog_full | pause_q;

    // ------------------------------------------------------------------------
    // State machine
    // ------------------------------------------------------------------------

    always_ff @(posedge ap_clk) begin
        if (areset_engine) begin
            state <= RESET;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            RESET: begin
                state_next = IDLE;
            end
            IDLE: begin
                if (cfg_accept) begin
                    state_next = SETUP;
                end
            end
            SETUP: begin
                state_next = BUSY;
            end
            BUSY: begin
                // End check first so a full FIFO cannot delay done
                if (!below_end) begin
                    state_next = DONE;
                end else if (hold) begin
                    state_next = PAUSE;
                end
            end
            PAUSE: begin
                if (!hold) begin
                    state_next = BUSY;
                end
            end
            DONE: begin
                state_next = IDLE;
            end
            default: begin
                state_next = RESET;
            end
        endcase
    end

    // Counter loads during SETUP so BUSY sees the start index
    assign counter_load = (state == SETUP);

    // Push and step together so each index is written exactly once
    assign push         = (state == BUSY) & below_end & ~hold;
    assign counter_step = push;

    // ------------------------------------------------------------------------
    // Status
    // ------------------------------------------------------------------------

    // An accept pending in IDLE already counts as a started run
    always_ff @(posedge ap_clk) begin
        if (areset_engine) begin
            ready <= 1'b0;
            done  <= 1'b0;
        end else begin
            ready <= (state == IDLE) & ~cfg_accept;
            done  <= ((state == IDLE) & ~cfg_accept) | (state == DONE);
        end
    end

    // ------------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------------

    // Pushes belong to a run, so done is low whenever one happens
    a_push_in_busy: assert property (
        @(posedge ap_clk) disable iff (areset_engine)
        push |-> !done
    ) else $error("index_sequencer: push while done reports no run in progress");

    a_ready_in_idle: assert property (
        @(posedge ap_clk) disable iff (areset_engine)
        ready |-> (state == IDLE)
    ) else $error("index_sequencer: ready high outside IDLE");

endmodule : index_sequencer

// ==== src/request_fifo.sv ====
// Depth must be a power of two; pops while empty and pushes while full are dropped

`timescale 1ns/1ps

`include "csr_gen_params.svh"

module request_fifo
    import mem_req_pkg::*;
(
    input  logic     ap_clk,
    input  logic     areset_engine,
    input  logic     push,
    input  mem_req_t push_data,
    input  logic     pop,
    output mem_req_t pop_data,
    output logic     pop_valid,
    output logic     empty,
    output logic     prog_full
);

    localparam int PTR_W = $clog2(`CSR_FIFO_DEPTH);
    localparam int CNT_W = PTR_W + 1;

    localparam logic [CNT_W-1:0] DEPTH_C  = CNT_W'(`CSR_FIFO_DEPTH);
    localparam logic [CNT_W-1:0] THRESH_C = CNT_W'(`CSR_FIFO_PROG_THRESH);

    mem_req_t mem [`CSR_FIFO_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] occupancy;
    logic             full;
    logic             wr_en;
    logic             rd_en;

    assign full      = (occupancy == DEPTH_C);
    assign empty     = (occupancy == '0);
    assign prog_full = (occupancy >= THRESH_C);

    assign wr_en = push & ~full;
    assign rd_en = pop & ~empty;

    // ------------------------------------------------------------------------
    // Storage and read register
    // ------------------------------------------------------------------------

    always_ff @(posedge ap_clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= push_data;
        end
        if (rd_en) begin
            pop_data <= mem[rd_ptr];
        end
    end

    // ------------------------------------------------------------------------
    // Pointers and occupancy
    // ------------------------------------------------------------------------

    always_ff @(posedge ap_clk) begin
        if (areset_engine) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            occupancy <= '0;
            pop_valid <= 1'b0;
        end else begin
            pop_valid <= rd_en;
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   occupancy <= occupancy + 1'b1;
                2'b01:   occupancy <= occupancy - 1'b1;
                default: occupancy <= occupancy;
            endcase
        end
    end

    // Producer backs off at prog_full, so full is never pushed into
    a_no_push_full: assert property (
        @(posedge ap_clk) disable iff (areset_engine)
        !(push && full)
    ) else $error("request_fifo: push while full");

endmodule : request_fifo

// ==== src/csr_index_generator.sv ====
// Configuration is taken only while ready is high; outputs hold their last value between pops

`timescale 1ns/1ps

`include "csr_gen_params.svh"

module csr_index_generator
    import csr_ctrl_pkg::*;
    import mem_req_pkg::*;
(
    input  logic                    ap_clk,
    input  logic                    areset_engine,
    input  logic                    cfg_valid,
    input  logic [`CSR_INDEX_W-1:0] cfg_index_start,
    input  logic [`CSR_INDEX_W-1:0] cfg_index_end,
    input  logic [`CSR_INDEX_W-1:0] cfg_stride,
    input  shift_dir_t              cfg_shift_dir,
    input  logic [`CSR_SHIFT_W-1:0] cfg_shift_amount,
    input  logic [`CSR_ROUTE_W-1:0] cfg_route,
    input  logic                    pause,
    input  logic                    req_pop,
    output logic                    req_valid,
    output logic [`CSR_ROUTE_W-1:0] req_route,
    output logic [`CSR_INDEX_W-1:0] req_offset,
    output logic [`CSR_INDEX_W-1:0] req_index,
    output logic                    ready,
    output logic                    done
);

    logic                    cfg_take;
    logic                    cfg_accept;
    logic [`CSR_INDEX_W-1:0] start_q;
    logic [`CSR_INDEX_W-1:0] end_q;
    logic [`CSR_INDEX_W-1:0] stride_q;
    shift_dir_t              dir_q;
    logic [`CSR_SHIFT_W-1:0] amount_q;
    logic [`CSR_ROUTE_W-1:0] route_q;

    logic                    counter_load;
    logic                    counter_step;
    logic [`CSR_INDEX_W-1:0] counter_count;
    logic                    fifo_push;
    logic                    fifo_pop_valid;
    logic                    fifo_prog_full;
    mem_req_t                push_req;
    mem_req_t                fifo_pop_data;

    // ------------------------------------------------------------------------
    // Configuration capture
    // ------------------------------------------------------------------------

    // Ready still reads high the cycle after an accept, so block a second take
    assign cfg_take = cfg_valid & ready & ~cfg_accept;

    always_ff @(posedge ap_clk) begin
        if (areset_engine) begin
            cfg_accept <= 1'b0;
        end else begin
            cfg_accept <= cfg_take;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (cfg_take) begin
            start_q  <= cfg_index_start;
            end_q    <= cfg_index_end;
            stride_q <= cfg_stride;
            dir_q    <= cfg_shift_dir;
            amount_q <= cfg_shift_amount;
            route_q  <= cfg_route;
        end
    end

    // ------------------------------------------------------------------------
    // Request formation
    // ------------------------------------------------------------------------

    always_comb begin
        push_req.route = route_q;
        push_req.index = counter_count;
        if (dir_q == SHIFT_LEFT) begin
            push_req.offset = counter_count << amount_q;
        end else begin
            push_req.offset = counter_count >> amount_q;
        end
    end

    index_counter u_counter (
        .ap_clk        (ap_clk),
        .areset_engine (areset_engine),
        .load          (counter_load),
        .step          (counter_step),
        .load_value    (start_q),
        .stride        (stride_q),
        .count         (counter_count)
    );

    index_sequencer u_sequencer (
        .ap_clk        (ap_clk),
        .areset_engine (areset_engine),
        .cfg_accept    (cfg_accept),
        .count         (counter_count),
        .index_end     (end_q),
        .prog_full     (fifo_prog_full),
        .pause         (pause),
        .counter_load  (counter_load),
        .counter_step  (counter_step),
        .push          (fifo_push),
        .ready         (ready),
        .done          (done)
    );

    request_fifo u_fifo (
        .ap_clk        (ap_clk),
        .areset_engine (areset_engine),
        .push          (fifo_push),
        .push_data     (push_req),
        .pop           (req_pop),
        .pop_data      (fifo_pop_data),
        .pop_valid     (fifo_pop_valid),
        .empty         (),
        .prog_full     (fifo_prog_full)
    );

    // ------------------------------------------------------------------------
    // Request output
    // ------------------------------------------------------------------------

    assign req_valid  = fifo_pop_valid;
    assign req_route  = fifo_pop_data.route;
    assign req_offset = fifo_pop_data.offset;
    assign req_index  = fifo_pop_data.index;

endmodule : csr_index_generator

// ==== sim/csr_ref_model.svh ====
// Include inside a module that imports csr_ctrl_pkg; stride must be nonzero for any request to be listed

`ifndef CSR_REF_MODEL_SVH
`define CSR_REF_MODEL_SVH

// Expected request, same field order as the request record
typedef struct packed {
    logic [`CSR_ROUTE_W-1:0] route;
    logic [`CSR_INDEX_W-1:0] offset;
    logic [`CSR_INDEX_W-1:0] index;
} exp_req_t;

typedef exp_req_t exp_req_q_t[$];

// All requests for one configuration, in the order they leave the FIFO
function automatic exp_req_q_t expected_requests(
    input logic [`CSR_INDEX_W-1:0] start,
    input logic [`CSR_INDEX_W-1:0] end_index,
    input logic [`CSR_INDEX_W-1:0] stride,
    input shift_dir_t              dir,
    input logic [`CSR_SHIFT_W-1:0] amount,
    input logic [`CSR_ROUTE_W-1:0] route
);
    exp_req_q_t            reqs;
    exp_req_t              item;
    logic [`CSR_INDEX_W:0] idx;
    idx = {1'b0, start};
    // Extra top bit keeps the walk finite near the top of the index range
    while ((idx < {1'b0, end_index}) && (stride != '0)) begin
        item.route  = route;
        item.index  = idx[`CSR_INDEX_W-1:0];
        item.offset = (dir == SHIFT_LEFT) ? (item.index << amount) : (item.index >> amount);
        reqs.push_back(item);
        idx = idx + {1'b0, stride};
    end
    return reqs;
endfunction

`endif

// ==== sim/tb_csr_index_generator.sv ====
// Runs must stay clear of index wrap; the watchdog budget grows as each run is queued

`timescale 1ns/1ps

`include "csr_gen_params.svh"

module tb_csr_index_generator
    import csr_ctrl_pkg::*;
();

    `include "csr_ref_model.svh"

    logic                    ap_clk;
    logic                    areset_engine;
    logic                    cfg_valid;
    logic [`CSR_INDEX_W-1:0] cfg_index_start;
    logic [`CSR_INDEX_W-1:0] cfg_index_end;
    logic [`CSR_INDEX_W-1:0] cfg_stride;
    shift_dir_t              cfg_shift_dir;
    logic [`CSR_SHIFT_W-1:0] cfg_shift_amount;
    logic [`CSR_ROUTE_W-1:0] cfg_route;
    logic                    pause;
    logic                    req_pop;
    logic                    req_valid;
    logic [`CSR_ROUTE_W-1:0] req_route;
    logic [`CSR_INDEX_W-1:0] req_offset;
    logic [`CSR_INDEX_W-1:0] req_index;
    logic                    ready;
    logic                    done;

    exp_req_q_t              exp_q;
    exp_req_t                front;
    int                      error_count;
    int                      test_count;
    int                      failed_tests;
    int                      test_start_errors;
    int                      total_expected;
    int                      watch_cycles;
    logic [`CSR_INDEX_W-1:0] stride_a;
    logic [`CSR_INDEX_W-1:0] stride_b;
    logic [`CSR_INDEX_W-1:0] stride_c;

    csr_index_generator dut0 (
        .ap_clk           (ap_clk),
        .areset_engine    (areset_engine),
        .cfg_valid        (cfg_valid),
        .cfg_index_start  (cfg_index_start),
        .cfg_index_end    (cfg_index_end),
        .cfg_stride       (cfg_stride),
        .cfg_shift_dir    (cfg_shift_dir),
        .cfg_shift_amount (cfg_shift_amount),
        .cfg_route        (cfg_route),
        .pause            (pause),
        .req_pop          (req_pop),
        .req_valid        (req_valid),
        .req_route        (req_route),
        .req_offset       (req_offset),
        .req_index        (req_index),
        .ready            (ready),
        .done             (done)
    );

    initial begin
        ap_clk = 1'b0;
        forever #10 ap_clk = ~ap_clk;
    end

    // ------------------------------------------------------------------------
    // Compare process and watchdog
    // ------------------------------------------------------------------------

    // Outputs settle after the rising edge, so look at them on the falling one
    always @(negedge ap_clk) begin
        if (!areset_engine && req_valid) begin
            if (exp_q.size() == 0) begin
                $display("Unexpected request with index %h when none was pending", req_index);
                error_count++;
            end else begin
                front = exp_q.pop_front();
                if (req_index !== front.index) begin
                    $display("** Error: req_index is %h, expected %h", req_index, front.index);
                    error_count++;
                end
                if (req_offset !== front.offset) begin
                    $display("** Error: req_offset is %h, expected %h", req_offset, front.offset);
                    error_count++;
                end
                if (req_route !== front.route) begin
                    $display("** Error: req_route is %h, expected %h", req_route, front.route);
                    error_count++;
                end
            end
        end
    end

    initial begin
        watch_cycles = 0;
        while (watch_cycles <= 2000 + 40 * total_expected) begin
            @(posedge ap_clk);
            watch_cycles++;
        end
        $display("Watchdog expired after %0d cycles with %0d requests still missing",
                 watch_cycles, exp_q.size());
        $display("Test FAILED");
        $finish;
    end

    // ------------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------------

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("** Error: %s is %h, expected %h", name, got, expected);
            error_count++;
        end
    endtask

    task automatic end_test(input string name);
        test_count++;
        if (error_count == test_start_errors) begin
            $display("[%0d] %s: pass", test_count, name);
        end else begin
            failed_tests++;
            $display("[%0d] %s: fail with %0d errors", test_count, name,
                     error_count - test_start_errors);
        end
        test_start_errors = error_count;
    endtask

    task automatic wait_for_ready(input int limit);
        int n;
        n = 0;
        while (ready !== 1'b1 && n < limit) begin
            @(negedge ap_clk);
            n++;
        end
        if (ready !== 1'b1) begin
            $display("Generator did not become ready within %0d cycles", limit);
            error_count++;
        end
    endtask

    // Pop modes: 0 frequent, 1 about half the cycles, 2 long stall then drain
    task automatic run_config(
        input logic [`CSR_INDEX_W-1:0] start,
        input logic [`CSR_INDEX_W-1:0] end_index,
        input logic [`CSR_INDEX_W-1:0] stride,
        input shift_dir_t              dir,
        input logic [`CSR_SHIFT_W-1:0] amount,
        input logic [`CSR_ROUTE_W-1:0] route,
        input int                      pop_mode,
        input bit                      use_pause,
        input bit                      send_stray
    );
        exp_req_q_t run_q;
        int         cycles;
        int         pause_left;
        run_q = expected_requests(start, end_index, stride, dir, amount, route);
        foreach (run_q[i]) begin
            exp_q.push_back(run_q[i]);
        end
        total_expected += run_q.size();
        wait_for_ready(50);
        @(negedge ap_clk);
        cfg_valid        = 1'b1;
        cfg_index_start  = start;
        cfg_index_end    = end_index;
        cfg_stride       = stride;
        cfg_shift_dir    = dir;
        cfg_shift_amount = amount;
        cfg_route        = route;
        @(negedge ap_clk);
        cfg_valid = 1'b0;
        cycles = 0;
        while (done === 1'b1 && cycles < 10) begin
            @(negedge ap_clk);
            cycles++;
        end
        if (done === 1'b1) begin
            $display("done stayed high after a configuration was sent");
            error_count++;
        end
        cycles     = 0;
        pause_left = 0;
        while (!(exp_q.size() == 0 && done === 1'b1)) begin
            @(negedge ap_clk);
            cycles++;
            case (pop_mode)
                0:       req_pop = ($urandom_range(0, 7) != 32'd0);
                1:       req_pop = ($urandom_range(0, 1) == 32'd1);
                default: req_pop = (cycles > 80);
            endcase
            if (use_pause) begin
                if (pause_left == 0) begin
                    pause      = ~pause;
                    pause_left = $urandom_range(1, 12);
                end else begin
                    pause_left--;
                end
            end
            // Bogus configuration while busy, must not be taken
            if (send_stray && cycles == 4 && ready === 1'b0) begin
                cfg_valid       = 1'b1;
                cfg_route       = ~route;
                cfg_index_start = '0;
                cfg_index_end   = 32'h0000_ffff;
            end else begin
                cfg_valid = 1'b0;
            end
        end
        req_pop   = 1'b0;
        pause     = 1'b0;
        cfg_valid = 1'b0;
        // Extra pops expose anything left behind in the FIFO
        repeat (4) begin
            @(negedge ap_clk);
            req_pop = 1'b1;
        end
        @(negedge ap_clk);
        req_pop = 1'b0;
        repeat (2) @(negedge ap_clk);
        check_value("done", 32'(done), 32'd1);
        check_value("ready", 32'(ready), 32'd1);
    endtask

    // ------------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------------

    initial begin
        void'($urandom(32'hbcab));
        error_count       = 0;
        test_count        = 0;
        failed_tests      = 0;
        test_start_errors = 0;
        total_expected    = 0;
        areset_engine     = 1'b1;
        cfg_valid         = 1'b0;
        cfg_index_start   = '0;
        cfg_index_end     = '0;
        cfg_stride        = '0;
        cfg_shift_dir     = SHIFT_RIGHT;
        cfg_shift_amount  = '0;
        cfg_route         = '0;
        pause             = 1'b0;
        req_pop           = 1'b0;
        stride_a          = $urandom_range(1, 9);
        stride_b          = $urandom_range(1, 9);
        stride_c          = $urandom_range(1, 5);

        repeat (3) @(posedge ap_clk);
        @(negedge ap_clk);
        check_value("req_valid", 32'(req_valid), 32'd0);
        check_value("ready", 32'(ready), 32'd0);
        check_value("done", 32'(done), 32'd0);
        areset_engine = 1'b0;
        wait_for_ready(10);
        repeat (20) begin
            @(negedge ap_clk);
            check_value("ready", 32'(ready), 32'd1);
            check_value("done", 32'(done), 32'd1);
            check_value("req_valid", 32'(req_valid), 32'd0);
        end
        end_test("reset and idle");

        run_config(32'h0000_1000, 32'h0000_1028, 32'd1, SHIFT_LEFT, 5'd3, 8'h5a, 0, 1'b0, 1'b0);
        end_test("left shift with frequent pops");

        run_config(32'h0000_0200, 32'h0000_0201 + stride_a * 32'd24, stride_a, SHIFT_RIGHT,
                   5'd2, 8'hc3, 1, 1'b0, 1'b1);
        run_config(32'h7fff_ff00, 32'h8000_0000, stride_b, SHIFT_RIGHT, 5'd17, 8'h3e, 1,
                   1'b0, 1'b0);
        end_test("right shift, random stride, two runs");

        run_config(32'h0000_0040, 32'h0000_0130, 32'd3, SHIFT_LEFT, 5'd2, 8'h81, 2, 1'b0, 1'b0);
        end_test("back-pressure then drain");

        run_config(32'h0000_0000, 32'h0000_0090, stride_c, SHIFT_LEFT, 5'd4, 8'h17, 0,
                   1'b1, 1'b0);
        end_test("random pause windows");

        run_config(32'h0000_0500, 32'h0000_0500, 32'd1, SHIFT_RIGHT, 5'd0, 8'h66, 0, 1'b0, 1'b0);
        run_config(32'h0000_0600, 32'h0000_0100, 32'd4, SHIFT_LEFT, 5'd1, 8'h99, 0, 1'b0, 1'b0);
        end_test("empty ranges");

        $display("Tests run %0d, tests failed %0d, errors %0d", test_count, failed_tests,
                 error_count);
        if (error_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule : tb_csr_index_generator

// ==== src.f ====
+incdir+src
+incdir+sim
src/csr_ctrl_pkg.sv
src/mem_req_pkg.sv
src/index_counter.sv
src/index_sequencer.sv
src/request_fifo.sv
src/csr_index_generator.sv
sim/tb_csr_index_generator.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the CSR index generator testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert --timescale 1ns/1ps \
    --top-module tb_csr_index_generator \
    -f src.f \
    --Mdir obj_dir -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "^Test OK$" sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed, see sim.log"
    exit 1
fi
